//--- test/wc_stim.txt
# T name : start of a case
# W byte_addr(hex) size_bytes(1,2,4) data(hex, right justified) flush(0/1)
# E dword_addr(hex) be(hex, msb is lane 0) data(hex, lane 0 first)
T single_byte
W 00001003 1 000000a5 0
W 00000000 1 00000000 1
E 00000200 10 000000a500000000
T mixed_sizes
W 00002000 4 11223344 0
W 00002002 2 0000aabb 0
W 00002003 1 000000cc 0
W 00002006 2 00005566 0
W 00000000 1 00000000 1
E 00000400 f3 1122aacc00005566
T fill_dword
W 00003000 1 000000a0 0
W 00003005 1 000000a5 0
W 00003002 1 000000a2 0
W 00003007 1 000000a7 0
W 00003001 1 000000a1 0
W 00003004 1 000000a4 0
W 00003006 1 000000a6 0
W 00003003 1 000000a3 0
E 00000600 ff a0a1a2a3a4a5a6a7
T new_dword
W 00004004 4 deadbeef 0
W 00004010 2 00001234 0
E 00000800 0f 00000000deadbeef
W 00000000 1 00000000 1
E 00000802 c0 1234000000000000
T empty_flush
W 00000000 1 00000000 1
W 00000000 1 00000000 1
W 00005001 1 0000005a 0
W 00000000 1 00000000 1
E 00000a00 40 005a000000000000
T backpressure
W 00006000 4 01020304 0
W 00006004 4 05060708 0
E 00000c00 ff 0102030405060708
W 00006008 2 0000a1b2 0
W 00006010 1 000000c3 0
E 00000c01 c0 a1b2000000000000
W 00006016 2 0000d4e5 0
W 00006018 4 f6a7b8c9 0
E 00000c02 83 c30000000000d4e5
W 00000000 1 00000000 1
E 00000c03 f0 f6a7b8c900000000

//--- build.f
logic/wc_pkg.sv
logic/byte_lane_steer.sv
logic/dword_stage.sv
logic/combine_ctrl.sv
logic/write_combiner.sv
test/tb_write_combiner.sv

//--- Bender.yml
package:
  name: write_combiner

sources:
  - files:
      - logic/wc_pkg.sv
      - logic/byte_lane_steer.sv
      - logic/dword_stage.sv
      - logic/combine_ctrl.sv
      - logic/write_combiner.sv
  - target: test
    files:
      - test/tb_write_combiner.sv

//--- test/tb_write_combiner.sv
`timescale 1ns/1ps

module tb_write_combiner import wc_pkg::*; ();

   // ----------------------------------------
   // DUT, clock and shared state
   // ----------------------------------------

   // Command entry, kind T opens a case, kind W is one write
   typedef struct packed {
      logic [7:0] kind;
      wr_req_t    wr;
   } cmd_t;

   logic       clk;
   logic       reset;
   wr_req_t    wr;
   logic       in_req;
   logic       in_ack;
   dword_out_t dout;
   logic       out_req;
   logic       out_ack;

   cmd_t       cmds[$];
   string      case_names[$];
   int         case_outputs[$];
   // Expected doublewords in arrival order
   dword_out_t expected[$];
   int         errors = 0;
   int         checks = 0;
   int         received = 0;
   int         stim_lines = 0;
   bit         loaded = 1'b0;

   write_combiner u_dut (
      .clk     (clk),
      .reset   (reset),
      .wr      (wr),
      .in_req  (in_req),
      .in_ack  (in_ack),
      .dout    (dout),
      .out_ack (out_ack),
      .out_req (out_req)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   // ----------------------------------------
   // Compare tasks
   // ----------------------------------------

   task automatic check_be(input string name, input be_t exp, input be_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAIL %0t %s expected %b got %b", $time, name, exp, act);
      end
   endtask

   task automatic check_dout(input string name, input dword_out_t exp, input dword_out_t act);
      dword_out_t exp_m;
      dword_out_t act_m;
      exp_m = exp;
      act_m = act;
      // Lanes without an enable hold stale bytes
      for (int l = 0; l < lane_count; l++) begin
         if (!exp.be[l]) begin
            exp_m.data[l] = '0;
            act_m.data[l] = '0;
         end
      end
      checks++;
      if (act_m !== exp_m) begin
         errors++;
         $display("FAIL %0t %s expected %h got %h", $time, name, exp_m, act_m);
      end
   endtask

   // ----------------------------------------
   // Stimulus file
   // ----------------------------------------

   task automatic load_stim(output bit ok);
      int          fd;
      int          n;
      int          want;
      int          size;
      int          flush;
      string       line;
      string       name;
      logic [31:0] a;
      logic [31:0] d32;
      logic [7:0]  be_v;
      logic [63:0] d64;
      cmd_t        c;
      dword_out_t  e;
      fd = $fopen("test/wc_stim.txt", "r");
      ok = (fd != 0);
      while (ok && $fgets(line, fd) > 0) begin
         // Skip blank and comment lines
         if (line.len() > 1 && line[0] != "#") begin
            stim_lines++;
            c = '0;
            c.kind = line[0];
            case (line[0])
               "T": begin
                  want = 1;
                  n = $sscanf(line, "T %s", name);
                  case_names.push_back(name);
                  case_outputs.push_back(0);
                  cmds.push_back(c);
               end
               "W": begin
                  want = 4;
                  n = $sscanf(line, "W %h %d %h %d", a, size, d32, flush);
                  c.wr.addr  = a;
                  c.wr.data  = d32;
                  c.wr.flush = (flush != 0);
                  // Size column counts bytes
                  c.wr.size  = (size == 4) ? size_word :
                               (size == 2) ? size_half : size_byte;
                  cmds.push_back(c);
               end
               "E": begin
                  want = 3;
                  n = $sscanf(line, "E %h %h %h", a, be_v, d64);
                  e.addr = a[dword_addr_width-1:0];
                  e.be   = be_v;
                  e.data = d64;
                  expected.push_back(e);
                  case_outputs[case_outputs.size()-1] += 1;
               end
               default: begin
                  want = 1;
                  n    = 0;
               end
            endcase
            if (n != want) begin
               errors++;
               $display("malformed stimulus line: %s", line);
            end
         end
      end
      if (ok) begin
         $fclose(fd);
      end
   endtask

   // ----------------------------------------
   // Input side driver
   // ----------------------------------------

   // Full four-phase cycle for one write
   task automatic send_write(input wr_req_t w);
      @(posedge clk);
      wr     <= w;
      in_req <= 1'b1;
      do @(posedge clk); while (!in_ack);
      in_req <= 1'b0;
      do @(posedge clk); while (in_ack);
   endtask

   // Case ends once all of its doublewords came out
   task automatic finish_case(input int idx, inout int target, input int errs_before);
      target += case_outputs[idx];
      while (received < target) @(posedge clk);
      if (errors == errs_before) begin
         $display("case %0d %s: ok", idx + 1, case_names[idx]);
      end else begin
         $display("case %0d %s: %0d errors", idx + 1, case_names[idx], errors - errs_before);
      end
   endtask

   initial begin
      bit ok;
      int cur;
      int target;
      int errs_before;
      $timeformat(-9, 0, " ns", 0);
      reset  <= 1'b1;
      in_req <= 1'b0;
      wr     <= '0;
      load_stim(ok);
      loaded = 1'b1;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      if (!ok) begin
         errors++;
         $display("could not open stimulus file test/wc_stim.txt");
      end else begin
         cur         = -1;
         target      = 0;
         errs_before = errors;
         foreach (cmds[i]) begin
            if (cmds[i].kind == "T") begin
               if (cur >= 0) begin
                  finish_case(cur, target, errs_before);
               end
               cur++;
               errs_before = errors;
            end else begin
               send_write(cmds[i].wr);
            end
         end
         if (cur >= 0) begin
            finish_case(cur, target, errs_before);
         end
         // Room for any stray doubleword
         repeat (20) @(posedge clk);
         if (expected.size() != 0) begin
            errors++;
            $display("%0d expected doublewords never arrived", expected.size());
         end
      end
      $display("summary: %0d cases, %0d outputs, %0d checks, %0d errors",
               case_names.size(), received, checks, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   // ----------------------------------------
   // Output responder
   // ----------------------------------------

   initial begin
      dword_out_t got;
      dword_out_t exp;
      int         delay;
      void'($urandom(32'h9f3d_c4f8));
      out_ack <= 1'b0;
      forever begin
         @(posedge clk);
         if (!reset && out_req === 1'b1 && out_ack === 1'b0) begin
            // dout is stable while out_req is high
            got = dout;
            if (expected.size() == 0) begin
               errors++;
               $display("unexpected doubleword %h at %0t with no expected entry left",
                        got, $time);
            end else begin
               exp = expected.pop_front();
               check_be("dout.be", exp.be, got.be);
               check_dout("dout", exp, got);
               received++;
            end
            // Random back-pressure
            delay = $urandom % 8;
            repeat (delay) @(posedge clk);
            out_ack <= 1'b1;
            do @(posedge clk); while (out_req);
            out_ack <= 1'b0;
         end
      end
   end

   // ----------------------------------------
   // Watchdog
   // ----------------------------------------

   initial begin
      int limit;
      wait (loaded);
      // 40 cycles per stimulus line plus margin
      limit = stim_lines * 40 + 200;
      repeat (limit) @(posedge clk);
      $display("watchdog: run did not finish within %0d cycles", limit);
      $display("test failed");
      $finish;
   end

endmodule

//--- logic/write_combiner.sv
`timescale 1ns/1ps

module write_combiner import wc_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  wr_req_t    wr,
   input  logic       in_req,
   output logic       in_ack,
   output dword_out_t dout,
   input  logic       out_ack,
   output logic       out_req
);

   // ----------------------------------------
   // Internal nets
   // ----------------------------------------

   // Steered write
   dword_t      lane_data;
   be_t         lane_be;
   // Stage contents
   dword_t      stage_data;
   be_t         stage_be;
   // Control strobes
   logic        merge;
   logic        clear;
   dword_addr_t open_addr;

   // ----------------------------------------
   // Datapath
   // ----------------------------------------

   byte_lane_steer u_steer (
      .clk       (clk),
      .in_req    (in_req),
      .wr        (wr),
      .lane_data (lane_data),
      .lane_be   (lane_be)
   );

   dword_stage u_stage (
      .clk       (clk),
      .reset     (reset),
      .lane_data (lane_data),
      .lane_be   (lane_be),
      .merge     (merge),
      .clear     (clear),
      .data      (stage_data),
      .be        (stage_be)
   );

   // ----------------------------------------
   // Control
   // ----------------------------------------

   combine_ctrl u_ctrl (
      .clk       (clk),
      .reset     (reset),
      .wr        (wr),
      .in_req    (in_req),
      .in_ack    (in_ack),
      .stage_be  (stage_be),
      .merge     (merge),
      .clear     (clear),
      .open_addr (open_addr),
      .out_req   (out_req),
      .out_ack   (out_ack)
   );

   // Outgoing doubleword straight from stage and open address
   assign dout.addr = open_addr;
   assign dout.data = stage_data;
   assign dout.be   = stage_be;

endmodule

//--- logic/combine_ctrl.sv
`timescale 1ns/1ps

module combine_ctrl import wc_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  wr_req_t     wr,
   input  logic        in_req,
   output logic        in_ack,
   input  be_t         stage_be,
   output logic        merge,
   output logic        clear,
   output dword_addr_t open_addr,
   output logic        out_req,
   input  logic        out_ack
);

   // ----------------------------------------
   // Write classification
   // ----------------------------------------

   ctrl_state_t state;
   ctrl_state_t state_next;
   dword_addr_t wr_dword;
   logic        stage_empty;
   logic        stage_full;
   logic        dword_hit;

   // Doubleword of the pending write
   assign wr_dword    = wr.addr[0:dword_addr_width-1];
   assign stage_empty = (stage_be == '0);
   assign stage_full  = &stage_be;
   assign dword_hit   = (wr_dword == open_addr);

   // ----------------------------------------
   // State register
   // ----------------------------------------

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= st_idle;
      end else begin
         state <= state_next;
      end
   end

   // ----------------------------------------
   // Next state
   // ----------------------------------------

   always_comb begin
      state_next = state;
      case (state)
         // Wait for a write
         st_idle: begin
            if (in_req) begin
               state_next = st_decide;
            end
         end
         // Merge, flush first, or ack right away
         st_decide: begin
            if (wr.flush) begin
               // Nothing staged, nothing to send
               if (stage_empty) begin
                  state_next = st_ack;
               end else begin
                  state_next = st_flush_req;
               end
            end else if (stage_empty || dword_hit) begin
               state_next = st_merge;
            end else begin
               // Miss, old doubleword goes out first
               state_next = st_flush_req;
            end
         end
         // One cycle merge pulse
         st_merge: begin
            state_next = st_ack;
         end
         // Hold ack until the writer lets go
         st_ack: begin
            if (!in_req) begin
               // Full doubleword leaves on its own
               if (stage_full) begin
                  state_next = st_flush_req;
               end else begin
                  state_next = st_idle;
               end
            end
         end
         // Output request phase
         st_flush_req: begin
            if (out_ack) begin
               state_next = st_flush_rel;
            end
         end
         // Wait for receiver to drop ack
         st_flush_rel: begin
            if (!out_ack) begin
               state_next = st_clear;
            end
         end
         // Stage empties here
         // A writer still waiting gets re-decided against the empty stage
         st_clear: begin
            if (in_req) begin
               state_next = st_decide;
            end else begin
               state_next = st_idle;
            end
         end
         default: begin
            state_next = st_idle;
         end
      endcase
   end

   // ----------------------------------------
   // Outputs
   // ----------------------------------------

   assign in_ack  = (state == st_ack);
   assign merge   = (state == st_merge);
   assign clear   = (state == st_clear);
   assign out_req = (state == st_flush_req);

   // Open doubleword follows the first write into an empty stage
   always_ff @(posedge clk) begin
      if (reset) begin
         open_addr <= '0;
      end else if (merge && stage_empty) begin
         open_addr <= wr_dword;
      end
   end

   // ----------------------------------------
   // Checks
   // ----------------------------------------

   // Four-phase rule on the output side
   out_req_hold_a : assert property (@(posedge clk) disable iff (reset)
      out_req && !out_ack |=> out_req)
      else $error("out_req dropped before out_ack");

   // Ack only answers a live request
   in_ack_rise_a : assert property (@(posedge clk) disable iff (reset)
      $rose(in_ack) |-> in_req)
      else $error("in_ack raised without in_req");

endmodule

//--- logic/dword_stage.sv
`timescale 1ns/1ps

module dword_stage import wc_pkg::*; (
   input  logic   clk,
   input  logic   reset,
   input  dword_t lane_data,
   input  be_t    lane_be,
   input  logic   merge,
   input  logic   clear,
   output dword_t data,
   output be_t    be
);

   // ----------------------------------------
   // Lane load strobes
   // ----------------------------------------

   be_t load;

   // Clear wins over merge
   assign load = lane_be & {lane_count{merge & ~clear}};

   // ----------------------------------------
   // Byte stores
   // ----------------------------------------

   // One 8-bit store per lane
   // Later writes to a lane overwrite it
   always_ff @(posedge clk) begin
      for (int l = 0; l < lane_count; l++) begin
         if (load[l]) begin
            data[l] <= lane_data[l];
         end
      end
   end

   // ----------------------------------------
   // Sticky byte enables
   // ----------------------------------------

   // Set by a lane load, held until reset or clear
   always_ff @(posedge clk) begin
      if (reset || clear) begin
         be <= '0;
      end else begin
         be <= be | load;
      end
   end

   // ----------------------------------------
   // Checks
   // ----------------------------------------

   // Control never asks to merge into a doubleword it is clearing
   merge_clear_a : assert property (@(posedge clk) disable iff (reset)
      !(merge && clear))
      else $error("merge and clear in the same cycle");

endmodule

//--- logic/byte_lane_steer.sv
`timescale 1ns/1ps

module byte_lane_steer import wc_pkg::*; (
   input  logic    clk,
   input  logic    in_req,
   input  wr_req_t wr,
   output dword_t  lane_data,
   output be_t     lane_be
);

   // ----------------------------------------
   // Start lane and byte count
   // ----------------------------------------

   logic [0:lane_sel_width-1] start_lane;
   int                        byte_count;
   logic                      aligned;

   // Low address bits select the first lane
   assign start_lane = wr.addr[addr_width-lane_sel_width:addr_width-1];

   always_comb begin
      case (wr.size)
         size_byte: begin
            byte_count = 1;
            aligned    = 1'b1;
         end
         size_half: begin
            byte_count = 2;
            // Halfword needs an even lane
            aligned    = (start_lane[lane_sel_width-1] == 1'b0);
         end
         size_word: begin
            byte_count = 4;
            // Word needs lane 0 or 4
            aligned    = (start_lane[lane_sel_width-2:lane_sel_width-1] == 2'b00);
         end
         default: begin
            // Illegal size code, no lanes
            byte_count = 0;
            aligned    = 1'b0;
         end
      endcase
   end

   // ----------------------------------------
   // Lane placement
   // ----------------------------------------

   // Big endian placement, lowest address gets the most significant used byte
   always_comb begin
      int offs;
      lane_data = '0;
      lane_be   = '0;
      for (int l = 0; l < lane_count; l++) begin
         offs = l - int'(start_lane);
         // Flush carries no data
         if (!wr.flush && offs >= 0 && offs < byte_count) begin
            lane_be[l]   = 1'b1;
            lane_data[l] = wr.data[data_bytes - byte_count + offs];
         end
      end
   end

   // ----------------------------------------
   // Checks
   // ----------------------------------------

   // Writer must keep each access inside its natural boundary
   wr_aligned_a : assert property (@(posedge clk) in_req && !wr.flush |-> aligned)
      else $error("misaligned write addr %h size %s", wr.addr, wr.size.name());

endmodule

//--- logic/wc_pkg.sv
package wc_pkg;

   // ----------------------------------------
   // Bus geometry
   // ----------------------------------------

   // CPU side byte address
   localparam int addr_width = 32;
   // Narrow write data, right justified
   localparam int data_width = 32;
   // System bus doubleword
   localparam int dword_width = 64;

   // Byte lanes in one doubleword
   localparam int lane_count = dword_width / 8;
   // Bytes in the narrow write data
   localparam int data_bytes = data_width / 8;
   // Address bits that pick the starting lane
   localparam int lane_sel_width = $clog2(lane_count);
   // Doubleword address, byte address minus lane bits
   localparam int dword_addr_width = addr_width - lane_sel_width;

   // ----------------------------------------
   // Lane types, lane 0 in the MSBs
   // ----------------------------------------

   typedef logic [0:7] byte_t;
   typedef byte_t [0:lane_count-1] dword_t;
   typedef logic [0:lane_count-1] be_t;
   typedef logic [0:dword_addr_width-1] dword_addr_t;

   // Write size codes
   typedef enum logic [0:1] {
      size_byte = 2'b00,
      size_half = 2'b01,
      size_word = 2'b10
   } wr_size_t;

   // ----------------------------------------
   // Port payloads
   // ----------------------------------------

   // One narrow CPU write
   typedef struct packed {
      logic [0:addr_width-1]     addr;
      wr_size_t                  size;
      byte_t [0:data_bytes-1]    data;   // data ignored when flush is set
      logic                      flush;
   } wr_req_t;

   // One staged doubleword toward the system bus
   typedef struct packed {
      dword_addr_t addr;
      dword_t      data;
      be_t         be;
   } dword_out_t;

   // Combine control FSM
   typedef enum logic [0:2] {
      st_idle,
      st_decide,
      st_merge,
      st_ack,
      st_flush_req,
      st_flush_rel,
      st_clear
   } ctrl_state_t;

endpackage
